// ==== memory_upload.f ====
rtl/upload_pkg.sv
rtl/byte_stream_if.sv
rtl/ddr_fetcher.sv
rtl/byte_fifo.sv
rtl/block_loader.sv
rtl/memory_upload.sv
verif/clock_gen.sv
verif/memory_upload_props.sv
verif/tb_memory_upload.sv

// ==== rtl/block_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

module block_loader (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        start,
    byte_stream_if.sink                in,
    output logic                       busy,
    output upload_pkg::error_t         error,
    output logic                       machine_type,
    output upload_pkg::ram_addr_t      ram_addr,
    output upload_pkg::byte_t          ram_din,
    output logic                       ram_ce,
    input  wire                        ram_ready,
    output logic                       layout_we,
    output upload_pkg::layout_index_t  layout_index,
    output upload_pkg::ref_ram_t       layout_ref_ram,
    output logic [1:0]                 layout_offset,
    output upload_pkg::mapper_t        layout_mapper
);
    import upload_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_header,
        st_record,
        st_fill,
        st_layout,
        st_drain
    } state_t;

    state_t        state;
    logic [2:0]    byte_cnt;
    byte_t         magic_byte;
    byte_t         conf1;                       // Slot, subslot, first page, extra pages
    byte_t         blk;
    byte_t         arg;                         // Page count or mapper code
    pattern_code_t pattern;
    ref_ram_t      ref_cnt;
    logic [1:0]    page;
    logic [1:0]    extra;
    logic [1:0]    offset;
    fill_count_t   fill_pos;
    fill_count_t   fill_end;
    logic          fill_rom;
    logic          is_mapper;
    logic          take;

    function automatic byte_t pattern_byte(pattern_code_t code, fill_count_t pos);
        case (code)
            pattern_ddr, pattern_ff: pattern_byte = 8'hFF;
            pattern_zero:            pattern_byte = 8'h00;
            pattern_03:              pattern_byte = (pos[1] ^ pos[8]) ? 8'h00 : 8'hFF;
            pattern_04:              pattern_byte = (pos[0] ^ pos[8]) ? 8'hFF : 8'h00;
            pattern_05:              pattern_byte = pos[7] ? 8'hFF : 8'h00;
            default:                 pattern_byte = 8'hFF;
        endcase
    endfunction

    always_comb begin
        case (byte_cnt[1:0])
            2'd0:    magic_byte = header_magic[23:16];
            2'd1:    magic_byte = header_magic[15:8];
            default: magic_byte = header_magic[7:0];
        endcase
    end

    assign fill_rom  = blk == block_rom;
    assign is_mapper = blk == block_mapper;
    assign fill_end  = fill_count_t'(arg) << page_shift;

    assign in.ack = (state == st_header) || (state == st_record) || (state == st_drain) ||
                    (state == st_fill && fill_rom && ram_ready);
    assign take   = in.valid && in.ack;

    // ROM bytes wait for both the stream and the RAM
    assign ram_ce  = (state == st_fill) && ram_ready && (!fill_rom || in.valid);
    assign ram_din = fill_rom ? in.data : pattern_byte(pattern, fill_pos);

    assign busy           = state != st_idle;
    assign layout_we      = state == st_layout;
    assign layout_index   = {conf1[7:6], conf1[5:4], page};
    assign layout_ref_ram = is_mapper ? '0 : ref_cnt;
    assign layout_offset  = is_mapper ? 2'd0 : offset;
    assign layout_mapper  = !layout_we ? mapper_none :
                            is_mapper ? mapper_t'(arg) : mapper_offset;

    always_ff @(posedge clk) begin
        if (!rst_n || start) begin
            state        <= start ? st_header : st_idle;
            error        <= err_none;
            machine_type <= 1'b0;
            ram_addr     <= '0;
            ref_cnt      <= '0;
            byte_cnt     <= '0;
        end else begin
            if (ram_ce) begin
                ram_addr <= ram_addr + 1'b1;
            end
            case (state)
                st_header: begin
                    if (take) begin
                        byte_cnt <= byte_cnt + 3'd1;
                        if (byte_cnt == 3'd3) begin
                            machine_type <= in.data[0];     // 1 is MSX2
                        end
                        if (byte_cnt != 3'd3 && in.data != magic_byte) begin
                            error <= err_bad_header;
                            state <= in.last ? st_idle : st_drain;
                        end else if (in.last) begin
                            error <= err_early_end;
                            state <= st_idle;
                        end else if (byte_cnt == 3'd3) begin
                            byte_cnt <= '0;
                            state    <= st_record;
                        end
                    end
                end
                st_record: begin
                    if (take) begin
                        byte_cnt <= byte_cnt + 3'd1;
                        if (in.last) begin                  // Image ends inside a record
                            error <= err_early_end;
                            state <= st_idle;
                        end
                        case (byte_cnt)
                            3'd0: begin
                                if (in.data == conf_end) begin
                                    error <= err_none;
                                    state <= in.last ? st_idle : st_drain;
                                end else if (in.data != conf_block) begin
                                    error <= err_bad_record;
                                    state <= in.last ? st_idle : st_drain;
                                end
                            end
                            3'd1: conf1 <= in.data;
                            3'd2: begin
                                blk <= in.data;
                                if (in.data != block_ram && in.data != block_rom &&
                                    in.data != block_mapper) begin
                                    error <= err_bad_block;
                                    state <= in.last ? st_idle : st_drain;
                                end
                            end
                            3'd3: arg <= in.data;
                            3'd4: pattern <= pattern_code_t'(in.data);
                            default: begin                  // Reserved byte closes the record
                                byte_cnt <= '0;
                                page     <= conf1[3:2];
                                extra    <= conf1[1:0];
                                offset   <= 2'd0;
                                fill_pos <= '0;
                                if (!in.last) begin
                                    state <= (is_mapper || arg == 8'd0) ? st_layout : st_fill;
                                end
                            end
                        endcase
                    end
                end
                st_fill: begin
                    if (ram_ce) begin
                        fill_pos <= fill_pos + 1'b1;
                        if (fill_rom && in.last) begin
                            error <= err_early_end;
                            state <= st_idle;
                        end else if (fill_pos == fill_end - 1'b1) begin
                            state <= st_layout;
                        end
                    end
                end
                st_layout: begin
                    page   <= page + 2'd1;                  // Wraps within the slot
                    offset <= offset + 2'd1;
                    extra  <= extra - 2'd1;
                    if (extra == 2'd0) begin
                        if (!is_mapper) begin
                            ref_cnt <= ref_cnt + 1'b1;
                        end
                        state <= st_record;
                    end
                end
                st_drain: begin
                    if (take && in.last) begin
                        state <= st_idle;
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/byte_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module byte_fifo (
    input  wire           clk,
    input  wire           rst_n,
    input  wire           start,
    byte_stream_if.sink   in,
    byte_stream_if.source out
);
    import upload_pkg::*;

    byte_t       data_mem [fifo_depth];
    logic        last_mem [fifo_depth];
    fifo_ptr_t   wr_ptr;
    fifo_ptr_t   rd_ptr;
    fifo_count_t count;
    logic        push;
    logic        pop;

    assign push      = in.valid;                // Credits keep this from overflowing
    assign pop       = out.valid && out.ack;
    assign out.valid = count != '0;
    assign out.data  = data_mem[rd_ptr];
    assign out.last  = last_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            data_mem[wr_ptr] <= in.data;
            last_mem[wr_ptr] <= in.last;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || start) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            in.ack <= 1'b0;
        end else begin
            in.ack <= pop;                      // One credit back per take
            if (push) begin
                wr_ptr <= (wr_ptr == fifo_ptr_t'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == fifo_ptr_t'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (!push && pop) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/byte_stream_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface byte_stream_if;
    import upload_pkg::*;

    logic  valid;
    byte_t data;
    logic  last;                                // Final byte of the image
    logic  ack;                                 // Credit or take, depending on the link

    modport source (output valid, output data, output last, input ack);
    modport sink   (input valid, input data, input last, output ack);

endinterface

`default_nettype wire

// ==== rtl/ddr_fetcher.sv ====
`timescale 1ns/1ps
`default_nettype none

module ddr_fetcher (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      start,
    input  upload_pkg::image_size_t  image_size,
    output upload_pkg::ddr_addr_t    ddr_addr,
    output logic                     ddr_rd,
    input  upload_pkg::byte_t        ddr_dout,
    input  wire                      ddr_ready,
    byte_stream_if.source            out
);
    import upload_pkg::*;

    image_size_t size;
    fifo_count_t credits;
    logic        spend;

    assign spend = ddr_rd && ddr_ready;                 // Byte arrives, one credit used

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            size      <= '0;
            ddr_addr  <= '0;
            ddr_rd    <= 1'b0;
            out.valid <= 1'b0;
            out.last  <= 1'b0;
            credits   <= fifo_count_t'(fifo_depth);
        end else if (start) begin
            size      <= image_size;
            ddr_addr  <= '0;
            ddr_rd    <= 1'b0;
            out.valid <= 1'b0;
            out.last  <= 1'b0;
            credits   <= fifo_count_t'(fifo_depth);
        end else begin
            out.valid <= 1'b0;
            if (spend) begin
                ddr_rd    <= 1'b0;
                out.valid <= 1'b1;
                out.last  <= (ddr_addr == size - 1'b1);
                ddr_addr  <= ddr_addr + 1'b1;
            end else if (!ddr_rd && credits != '0 && ddr_addr < size) begin
                ddr_rd <= 1'b1;                         // Address is stable until ready
            end

            if (spend && !out.ack) begin
                credits <= credits - 1'b1;
            end else if (!spend && out.ack) begin
                credits <= credits + 1'b1;
            end
        end
    end

    // Captured byte is held while valid pulses
    always_ff @(posedge clk) begin
        if (spend) begin
            out.data <= ddr_dout;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/memory_upload.sv ====
`timescale 1ns/1ps
`default_nettype none

module memory_upload (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        start,
    input  upload_pkg::image_size_t    image_size,
    output upload_pkg::ddr_addr_t      ddr_addr,
    output logic                       ddr_rd,
    input  upload_pkg::byte_t          ddr_dout,
    input  wire                        ddr_ready,
    output upload_pkg::ram_addr_t      ram_addr,
    output upload_pkg::byte_t          ram_din,
    output logic                       ram_ce,
    input  wire                        ram_ready,
    output logic                       busy,
    output upload_pkg::error_t         error,
    output logic                       machine_type,
    output logic                       layout_we,
    output upload_pkg::layout_index_t  layout_index,
    output upload_pkg::ref_ram_t       layout_ref_ram,
    output logic [1:0]                 layout_offset,
    output upload_pkg::mapper_t        layout_mapper
);

    byte_stream_if fetch_link ();               // Credit based
    byte_stream_if load_link ();                // Valid and take

    ddr_fetcher fetcher_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .image_size (image_size),
        .ddr_addr   (ddr_addr),
        .ddr_rd     (ddr_rd),
        .ddr_dout   (ddr_dout),
        .ddr_ready  (ddr_ready),
        .out        (fetch_link.source)
    );

    byte_fifo fifo_i (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start),
        .in    (fetch_link.sink),
        .out   (load_link.source)
    );

    block_loader loader_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .start          (start),
        .in             (load_link.sink),
        .busy           (busy),
        .error          (error),
        .machine_type   (machine_type),
        .ram_addr       (ram_addr),
        .ram_din        (ram_din),
        .ram_ce         (ram_ce),
        .ram_ready      (ram_ready),
        .layout_we      (layout_we),
        .layout_index   (layout_index),
        .layout_ref_ram (layout_ref_ram),
        .layout_offset  (layout_offset),
        .layout_mapper  (layout_mapper)
    );

endmodule

`default_nettype wire

// ==== rtl/upload_pkg.sv ====
`default_nettype none

package upload_pkg;

    typedef logic [7:0]  byte_t;                // Image or memory byte
    typedef logic [26:0] ddr_addr_t;            // External memory byte address
    typedef logic [26:0] image_size_t;
    typedef logic [19:0] ram_addr_t;            // Main memory byte address
    typedef logic [5:0]  layout_index_t;        // Slot, subslot, page
    typedef logic [4:0]  ref_ram_t;
    typedef logic [2:0]  mapper_t;
    typedef logic [2:0]  pattern_code_t;
    typedef logic [2:0]  error_t;
    typedef logic [9:0]  fill_count_t;          // Bytes of one region

    localparam int fifo_depth = 4;              // Entries and credits
    localparam int page_shift = 8;              // 256 byte pages

    typedef logic [$clog2(fifo_depth)-1:0]     fifo_ptr_t;
    typedef logic [$clog2(fifo_depth + 1)-1:0] fifo_count_t;

    localparam mapper_t mapper_none   = 3'd0;
    localparam mapper_t mapper_offset = 3'd1;

    localparam pattern_code_t pattern_ddr  = 3'd0;
    localparam pattern_code_t pattern_ff   = 3'd1;
    localparam pattern_code_t pattern_zero = 3'd2;
    localparam pattern_code_t pattern_03   = 3'd3;
    localparam pattern_code_t pattern_04   = 3'd4;
    localparam pattern_code_t pattern_05   = 3'd5;

    localparam error_t err_none       = 3'd0;
    localparam error_t err_bad_header = 3'd1;
    localparam error_t err_bad_record = 3'd2;
    localparam error_t err_bad_block  = 3'd3;
    localparam error_t err_early_end  = 3'd4;

    localparam byte_t conf_block = 8'h01;
    localparam byte_t conf_end   = 8'hFF;

    localparam byte_t block_ram    = 8'd0;
    localparam byte_t block_rom    = 8'd1;
    localparam byte_t block_mapper = 8'd2;

    localparam logic [23:0] header_magic = "MSx";

endpackage

`default_nettype wire

// ==== verif/clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
    output logic clk,
    output logic rst_n
);
    localparam int half_period  = 20;           // 40 ns clock
    localparam int reset_cycles = 10;

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst_n = 1'b1;                           // Released just after an edge
    end

endmodule

`default_nettype wire

// ==== verif/memory_upload_cases.txt ====
# name expected_error expected_machine_type image_bytes_in_hex ending with a dot
# gen N stands for N pseudo random image bytes
header_msx2 0 1 4D 53 78 01 FF .
header_msx1_tail 0 0 4D 53 78 00 FF 12 34 56 .
bad_magic 1 0 4D 53 58 01 01 40 00 01 01 00 FF .
ram_ff 0 1 4D 53 78 01 01 40 00 01 01 00 FF .
ram_ddr_zero 0 1 4D 53 78 01 01 85 00 01 00 00 01 C0 00 01 02 00 FF .
ram_03_wrap 0 0 4D 53 78 00 01 0F 00 02 03 00 FF .
ram_04_05 0 1 4D 53 78 01 01 F0 00 02 04 00 01 E1 00 01 05 00 FF .
rom_copy 0 1 4D 53 78 01 01 44 01 01 00 00 gen 256 01 48 00 01 02 00 FF .
rom_long 0 0 4D 53 78 00 01 32 01 03 00 00 gen 768 01 36 00 01 05 00 FF 00 .
mapper_pages 0 1 4D 53 78 01 01 4B 02 05 00 00 01 40 00 01 01 00 01 8C 02 03 00 00 FF .
bad_record 2 0 4D 53 78 00 02 11 22 33 44 55 66 .
bad_block 3 1 4D 53 78 01 01 40 00 01 01 00 01 40 07 01 00 00 FF .
early_end_record 4 1 4D 53 78 01 01 40 00 01 01 00 01 50 00 .
early_end_rom 4 0 4D 53 78 00 01 40 01 02 00 00 gen 100 .
early_end_no_end 4 1 4D 53 78 01 01 40 00 01 02 00 .

// ==== verif/memory_upload_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module memory_upload_props (
    input wire                    clk,
    input wire                    rst_n,
    input wire                    start,
    input upload_pkg::ddr_addr_t  ddr_addr,
    input wire                    ddr_rd,
    input wire                    ddr_ready,
    input wire                    ram_ce,
    input wire                    ram_ready,
    input wire                    credit_ack
);
    import upload_pkg::*;

    int in_flight;                              // Fetched bytes not yet returned as credit
    int fail_count = 0;                         // Assertion failures so far

    always_ff @(posedge clk) begin
        if (!rst_n || start) begin
            in_flight <= 0;
        end else begin
            in_flight <= in_flight + int'(ddr_rd && ddr_ready) - int'(credit_ack);
        end
    end

    ram_write_needs_ready: assert property (
        @(posedge clk) disable iff (!rst_n) ram_ce |-> ram_ready
    ) else begin
        $error("RAM write issued while ram_ready is low");
        fail_count++;
    end

    ddr_read_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        (ddr_rd && !ddr_ready) |=> (ddr_rd && $stable(ddr_addr))
    ) else begin
        $error("DDR read dropped or address moved before ddr_ready");
        fail_count++;
    end

    fetches_bounded: assert property (
        @(posedge clk) disable iff (!rst_n) (in_flight >= 0) && (in_flight <= fifo_depth)
    ) else begin
        $error("More fetches in flight than FIFO entries");
        fail_count++;
    end

endmodule

bind memory_upload memory_upload_props props_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .ddr_addr   (ddr_addr),
    .ddr_rd     (ddr_rd),
    .ddr_ready  (ddr_ready),
    .ram_ce     (ram_ce),
    .ram_ready  (ram_ready),
    .credit_ack (fetch_link.ack)
);

`default_nettype wire

// ==== verif/tb_memory_upload.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_memory_upload;
    import upload_pkg::*;

    localparam int mem_size    = 4096;
    localparam int drive_delay = 1;             // After the rising edge
    localparam int busy_limit  = 100000;
    localparam int reset_limit = 100;

    logic          clk;
    logic          rst_n;
    logic          start;
    image_size_t   image_size;
    ddr_addr_t     ddr_addr;
    logic          ddr_rd;
    byte_t         ddr_dout;
    logic          ddr_ready;
    ram_addr_t     ram_addr;
    byte_t         ram_din;
    logic          ram_ce;
    logic          ram_ready;
    logic          busy;
    error_t        error;
    logic          machine_type;
    logic          layout_we;
    layout_index_t layout_index;
    ref_ram_t      layout_ref_ram;
    logic [1:0]    layout_offset;
    mapper_t       layout_mapper;

    byte_t         ddr_mem [mem_size];          // External memory model
    int            image_len;
    logic [31:0]   rom_rng;
    logic [31:0]   drv_rng;
    int            ddr_wait;
    int            ram_stall;

    ram_addr_t     got_addr_q [$];
    byte_t         got_data_q [$];
    logic [15:0]   got_layout_q [$];
    byte_t         exp_data_q [$];
    logic [15:0]   exp_layout_q [$];

    clock_gen clk_gen_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    memory_upload dut_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .start          (start),
        .image_size     (image_size),
        .ddr_addr       (ddr_addr),
        .ddr_rd         (ddr_rd),
        .ddr_dout       (ddr_dout),
        .ddr_ready      (ddr_ready),
        .ram_addr       (ram_addr),
        .ram_din        (ram_din),
        .ram_ce         (ram_ce),
        .ram_ready      (ram_ready),
        .busy           (busy),
        .error          (error),
        .machine_type   (machine_type),
        .layout_we      (layout_we),
        .layout_index   (layout_index),
        .layout_ref_ram (layout_ref_ram),
        .layout_offset  (layout_offset),
        .layout_mapper  (layout_mapper)
    );

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Fill byte at a position inside a RAM region
    function automatic byte_t expected_fill(input pattern_code_t code, input int pos);
        byte_t b;
        case (code)
            pattern_zero: b = 8'h00;
            pattern_03: begin
                b = pos[1] ? 8'h00 : 8'hFF;
                if (pos[8]) begin
                    b = ~b;
                end
            end
            pattern_04: begin
                b = pos[0] ? 8'hFF : 8'h00;
                if (pos[8]) begin
                    b = ~b;
                end
            end
            pattern_05: b = pos[7] ? 8'hFF : 8'h00;
            default:    b = 8'hFF;              // Both ddr and ff
        endcase
        return b;
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            stop_with_failure($sformatf("ERROR %s: expected %0h, actual %0h",
                                        what, expected, actual));
        end
    endtask

    // Walks the loaded image and queues the writes it should produce
    task automatic predict_load(output error_t err, output logic mt);
        int            pos;
        int            last;
        int            count;
        int            avail;
        int            i;
        int            p;
        byte_t         code;
        byte_t         conf1;
        byte_t         blk;
        byte_t         arg;
        pattern_code_t pattern;
        ref_ram_t      ref_num;
        logic [1:0]    page;
        logic          done;
        exp_data_q.delete();
        exp_layout_q.delete();
        err     = err_none;
        mt      = 1'b0;
        ref_num = '0;
        last    = image_len - 1;
        done    = 1'b0;
        if (ddr_mem[0] != 8'h4D || ddr_mem[1] != 8'h53 || ddr_mem[2] != 8'h78) begin
            err  = err_bad_header;
            done = 1'b1;
        end else begin
            mt = ddr_mem[3][0];
            if (last <= 3) begin
                err  = err_early_end;
                done = 1'b1;
            end
        end
        pos = 4;
        while (!done) begin
            code    = ddr_mem[pos];
            conf1   = ddr_mem[pos + 1];
            blk     = ddr_mem[pos + 2];
            arg     = ddr_mem[pos + 3];
            pattern = pattern_code_t'(ddr_mem[pos + 4]);
            done    = 1'b1;
            if (code == conf_end) begin
                err = err_none;
            end else if (code != conf_block) begin
                err = err_bad_record;
            end else if (pos + 2 > last) begin
                err = err_early_end;
            end else if (blk > block_mapper) begin
                err = err_bad_block;
            end else if (pos + 5 >= last) begin
                err = err_early_end;                // Image ends inside the record
            end else begin
                done  = 1'b0;
                pos   = pos + 6;
                count = int'(arg) * 256;
                if (blk == block_ram) begin
                    for (i = 0; i < count; i++) begin
                        exp_data_q.push_back(expected_fill(pattern, i));
                    end
                end else if (blk == block_rom) begin
                    avail = last + 1 - pos;
                    if (avail <= count) begin
                        for (i = 0; i < avail; i++) begin
                            exp_data_q.push_back(ddr_mem[pos + i]);
                        end
                        err  = err_early_end;
                        done = 1'b1;
                    end else begin
                        for (i = 0; i < count; i++) begin
                            exp_data_q.push_back(ddr_mem[pos + i]);
                        end
                        pos = pos + count;
                    end
                end
                if (!done) begin
                    page = conf1[3:2];
                    for (p = 0; p <= int'(conf1[1:0]); p++) begin
                        if (blk == block_mapper) begin
                            exp_layout_q.push_back({conf1[7:4], page, 5'd0, 2'd0,
                                                    mapper_t'(arg)});
                        end else begin
                            exp_layout_q.push_back({conf1[7:4], page, ref_num, p[1:0],
                                                    mapper_offset});
                        end
                        page = page + 2'd1;
                    end
                    if (blk != block_mapper) begin
                        ref_num = ref_num + 1'b1;
                    end
                end
            end
        end
    endtask

    // Reads image tokens up to the closing dot and expands gen N into N random bytes
    task automatic read_image(input int fd);
        logic [8*32-1:0] tok;
        int              value;
        int              rc;
        int              k;
        image_len = 0;
        rc = $fscanf(fd, "%s", tok);
        while (rc == 1 && tok != ".") begin
            if (tok == "gen") begin
                rc = $fscanf(fd, "%d", value);
                for (k = 0; k < value; k++) begin
                    rom_rng = next_random(rom_rng);
                    ddr_mem[image_len] = rom_rng[7:0];
                    image_len++;
                end
            end else begin
                rc = $sscanf(tok, "%h", value);
                ddr_mem[image_len] = byte_t'(value);
                image_len++;
            end
            rc = $fscanf(fd, "%s", tok);
        end
        if (rc != 1) begin
            stop_with_failure("A case line ends without its closing dot");
        end
    endtask

    task automatic run_case(input string name, input int exp_err, input int exp_mt);
        error_t pred_err;
        logic   pred_mt;
        int     cycles;
        int     i;
        predict_load(pred_err, pred_mt);
        check_value({name, " predicted error"}, exp_err, pred_err);
        check_value({name, " predicted machine type"}, exp_mt, pred_mt);
        got_addr_q.delete();
        got_data_q.delete();
        got_layout_q.delete();
        @(posedge clk);
        #(drive_delay);
        start      = 1'b1;
        image_size = image_size_t'(image_len);
        @(posedge clk);
        #(drive_delay);
        start = 1'b0;
        check_value({name, " busy after start"}, 1, busy);
        cycles = 0;
        while (busy) begin
            @(posedge clk);
            #(drive_delay);
            cycles++;
            if (cycles > busy_limit) begin
                stop_with_failure({"Timeout: busy never fell in test ", name});
            end
        end
        check_value({name, " error"}, exp_err, error);
        check_value({name, " machine type"}, exp_mt, machine_type);
        check_value({name, " RAM write count"}, exp_data_q.size(), got_data_q.size());
        for (i = 0; i < got_data_q.size(); i++) begin
            check_value($sformatf("%s RAM address of write %0d", name, i), i, got_addr_q[i]);
            check_value($sformatf("%s RAM data at %0h", name, i), exp_data_q[i],
                        got_data_q[i]);
        end
        check_value({name, " layout write count"}, exp_layout_q.size(), got_layout_q.size());
        for (i = 0; i < got_layout_q.size(); i++) begin
            check_value($sformatf("%s layout write %0d", name, i), exp_layout_q[i],
                        got_layout_q[i]);
        end
    endtask

    // Write monitor
    always @(posedge clk) begin
        if (rst_n && ram_ce) begin
            got_addr_q.push_back(ram_addr);
            got_data_q.push_back(ram_din);
        end
        if (rst_n && layout_we) begin
            got_layout_q.push_back({layout_index, layout_ref_ram, layout_offset,
                                    layout_mapper});
        end
    end

    // Any failed bound assertion ends the run
    always @(posedge clk) begin
        if (dut_i.props_i.fail_count != 0) begin
            stop_with_failure("A bound assertion failed");
        end
    end

    // DDR responder and RAM stalls
    initial begin
        drv_rng   = 32'd15;
        ddr_ready = 1'b0;
        ddr_dout  = '0;
        ram_ready = 1'b0;
        ddr_wait  = 0;
        ram_stall = 0;
        forever begin
            @(posedge clk);
            #(drive_delay);
            drv_rng = next_random(drv_rng);
            if (ram_stall > 0) begin
                ram_ready = 1'b0;
                ram_stall--;
            end else begin
                ram_ready = drv_rng[2:0] != 3'd0;
                if (drv_rng[9:4] == 6'd0) begin
                    ram_stall = int'(drv_rng[14:10]);   // Long stall now and then
                end
            end
            if (ddr_ready) begin
                ddr_ready = 1'b0;
                ddr_wait  = (drv_rng[17:16] == 2'd0) ? int'(drv_rng[22:18]) :
                                                        int'(drv_rng[19:18]);
            end else if (ddr_rd) begin
                if (ddr_wait == 0) begin
                    ddr_ready = 1'b1;
                    ddr_dout  = ddr_mem[ddr_addr[11:0]];
                end else begin
                    ddr_wait--;
                end
            end
        end
    end

    initial begin : main_flow
        int              fd;
        int              rc;
        int              i;
        int              cycles;
        int              n_cases;
        int              exp_err;
        int              exp_mt;
        logic [8*32-1:0] tok;
        logic [8*128-1:0] skip_line;
        start      = 1'b0;
        image_size = '0;
        rom_rng    = 32'd15;
        for (i = 0; i < mem_size; i++) begin
            ddr_mem[i] = byte_t'(i) ^ byte_t'(i >> 8) ^ 8'hA5;
        end
        fd = $fopen("verif/memory_upload_cases.txt", "r");
        if (fd == 0) begin
            stop_with_failure("Cannot open verif/memory_upload_cases.txt");
        end
        cycles = 0;
        while (!rst_n) begin
            @(posedge clk);
            #(drive_delay);
            cycles++;
            if (cycles > reset_limit) begin
                stop_with_failure("Reset was never released");
            end
        end
        n_cases = 0;
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok == "#") begin
                rc = $fgets(skip_line, fd);
            end else begin
                rc = $fscanf(fd, "%d %d", exp_err, exp_mt);
                read_image(fd);
                run_case($sformatf("%0s", tok), exp_err, exp_mt);
                n_cases++;
            end
        end
        $fclose(fd);
        if (n_cases == 0) begin
            stop_with_failure("The cases file holds no test");
        end else if (dut_i.props_i.fail_count != 0) begin
            stop_with_failure("A bound assertion failed");
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

`default_nettype wire
